/* filelist.f */
+incdir+.
udp_regs_pkg.sv
seg_decoder.sv
front_panel.sv
udp_reply_tx.sv
udp_reg_bank.sv
udp_cmd_parser.sv
udp_regs_top.sv
tb_udp_regs_check.sv
tb_udp_regs.sv

/* front_panel.sv */
// front panel: picks the word for the digits from the switches and keeps the led byte
`timescale 1ns/1ps
`include "udp_regs_settings.svh"

module front_panel (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic [2:0]                                    i_sw,
  input  logic [`UDP_REGS_NUM-1:0][`UDP_REGS_WIDTH-1:0] i_regs,
  input  udp_regs_pkg::reg_rsp_t                        i_rsp,
  input  logic                                          i_rsp_valid,
  output logic [31:0]                                   o_hex_word,
  output logic [7:0]                                    o_led
);

  localparam int IDX_W = $clog2(`UDP_REGS_NUM);

  logic [31:0] last_ip;
  logic [31:0] ip_shown;
  logic [31:0] word_next;

  // new requester shows up together with the register update
  assign ip_shown = i_rsp_valid ? i_rsp.ip : last_ip;

  always_comb begin
    word_next = '0;
    if (i_sw < 3'(`UDP_REGS_NUM)) begin
      // index on the upper digits, value on the lower
      word_next = {16'(i_sw), i_regs[i_sw[IDX_W-1:0]]};
    end else if (i_sw == 3'd4) begin
      word_next = ip_shown;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_ip <= '0;
      o_led <= '0;
      o_hex_word <= '0;
    end else begin
      o_hex_word <= word_next;
      if (i_rsp_valid) begin
        last_ip <= i_rsp.ip;
        // first reply byte
        o_led <= i_rsp.opcode;
      end
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the udp register bank testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_udp_regs \
  -o tb_udp_regs_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/tb_udp_regs_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
  exit 0
fi
exit 1

/* seg_decoder.sv */
// seven-segment decoder: eight hex digits to segment patterns with board polarity
`timescale 1ns/1ps
`include "udp_regs_settings.svh"

module seg_decoder (
  input  logic [31:0]                  i_hex_word,
  output udp_regs_pkg::seg_t [7:0]     o_hex
);

  // active high pattern, bit 0 is segment a
  function automatic udp_regs_pkg::seg_t hex_to_seg(input logic [3:0] nib);
    udp_regs_pkg::seg_t seg;
    case (nib)
      4'h0: seg = 7'h3F;
      4'h1: seg = 7'h06;
      4'h2: seg = 7'h5B;
      4'h3: seg = 7'h4F;
      4'h4: seg = 7'h66;
      4'h5: seg = 7'h6D;
      4'h6: seg = 7'h7D;
      4'h7: seg = 7'h07;
      4'h8: seg = 7'h7F;
      4'h9: seg = 7'h6F;
      4'hA: seg = 7'h77;
      // lower case b and d
      4'hB: seg = 7'h7C;
      4'hC: seg = 7'h39;
      4'hD: seg = 7'h5E;
      4'hE: seg = 7'h79;
      default: seg = 7'h71;
    endcase
    return seg;
  endfunction

  // digit 0 is the lowest nibble
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      if (`UDP_REGS_HEX_INVERT != 0) begin
        o_hex[i] = ~hex_to_seg(i_hex_word[i*4 +: 4]);
      end else begin
        o_hex[i] = hex_to_seg(i_hex_word[i*4 +: 4]);
      end
    end
  end

endmodule

/* tb_udp_regs.sv */
// testbench top: clock, reset, udp request stimulus, reference model and timeout
`timescale 1ns/1ps

module tb_udp_regs;

  localparam int N_FRAMES = 30;
  localparam int MAX_CYCLES = 40 * N_FRAMES + 200;
  localparam logic [15:0] PORT = 16'd1234;
  localparam logic [7:0] OP_WRITE = 8'h01;
  localparam logic [7:0] OP_READ = 8'h02;

  logic                      clk = 1'b0;
  logic                      rst;
  udp_regs_pkg::udp_rx_hdr_t rx_hdr;
  logic                      rx_hdr_valid;
  logic                      rx_hdr_ready;
  udp_regs_pkg::axis_byte_t  rx_payload;
  logic                      rx_payload_valid;
  logic                      rx_payload_ready;
  udp_regs_pkg::udp_tx_hdr_t tx_hdr;
  logic                      tx_hdr_valid;
  logic                      tx_hdr_ready;
  udp_regs_pkg::axis_byte_t  tx_payload;
  logic                      tx_payload_valid;
  logic                      tx_payload_ready;
  logic [2:0]                sw;
  udp_regs_pkg::seg_t [7:0]  hex;
  logic [7:0]                led;
  // reference state
  logic [15:0]               model_regs [4];
  logic [31:0]               model_ip;
  logic [7:0]                model_led;
  int                        cycles = 0;

  always #2 clk = ~clk;

  udp_regs_top u_dut (
    .clk (clk), .rst (rst),
    .i_rx_hdr (rx_hdr), .i_rx_hdr_valid (rx_hdr_valid), .o_rx_hdr_ready (rx_hdr_ready),
    .i_rx_payload (rx_payload), .i_rx_payload_valid (rx_payload_valid),
    .o_rx_payload_ready (rx_payload_ready),
    .o_tx_hdr (tx_hdr), .o_tx_hdr_valid (tx_hdr_valid), .i_tx_hdr_ready (tx_hdr_ready),
    .o_tx_payload (tx_payload), .o_tx_payload_valid (tx_payload_valid),
    .i_tx_payload_ready (tx_payload_ready),
    .i_sw (sw), .o_hex (hex), .o_led (led)
  );

  tb_udp_regs_check u_check (
    .clk (clk), .rst (rst),
    .i_rx_hdr_valid (rx_hdr_valid), .i_rx_hdr_ready (rx_hdr_ready),
    .i_tx_hdr (tx_hdr), .i_tx_hdr_valid (tx_hdr_valid), .i_tx_hdr_ready (tx_hdr_ready),
    .i_tx_payload (tx_payload), .i_tx_payload_valid (tx_payload_valid),
    .i_tx_payload_ready (tx_payload_ready),
    .i_hex (hex), .i_led (led)
  );

  task automatic end_run(input bit timed_out);
    int missing;
    missing = u_check.pending_replies();
    $display("errors: %0d value, %0d protocol, %0d replies missing",
             u_check.n_value_err, u_check.n_proto_err, missing);
    if (timed_out || (u_check.n_value_err + u_check.n_proto_err + missing) != 0) begin
      $display("STATUS: FAIL");
    end else begin
      $display("STATUS: PASS");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      end_run(1'b1);
    end
  end

  // random reply side back-pressure, ready three times in four
  always @(posedge clk) begin
    #1;
    tx_hdr_ready <= ($urandom % 4) != 0;
    tx_payload_ready <= ($urandom % 4) != 0;
  end

  // drop rules and register update, returns 1 when a reply is due
  function automatic bit model_frame(input logic [15:0] dport, input int len,
      input bit bad_user, input logic [7:0] op, input logic [7:0] idx,
      input logic [15:0] data, input logic [31:0] ip, input logic [15:0] port,
      output udp_regs_pkg::reg_rsp_t rsp);
    bit ok;
    ok = (dport == PORT) && (len == 4) && !bad_user &&
         ((op == OP_WRITE) || (op == OP_READ)) && (idx < 8'd4);
    rsp = '0;
    if (ok) begin
      if (op == OP_WRITE) begin
        model_regs[idx[1:0]] = data;
      end
      rsp.opcode = op;
      rsp.index = idx;
      rsp.value = model_regs[idx[1:0]];
      rsp.ip = ip;
      rsp.port = port;
      model_ip = ip;
      model_led = op;
    end
    return ok;
  endfunction

  // starts and ends 1 ns after a rising edge
  task automatic send_frame(input logic [15:0] dport, input int len, input bit bad_user,
      input logic [7:0] op, input logic [7:0] idx, input logic [15:0] data);
    udp_regs_pkg::reg_rsp_t rsp;
    logic [7:0]             bytes [5];
    logic [31:0]            ip;
    logic [15:0]            port;
    bit                     due;
    ip = {24'hC0A801, 8'($urandom)};
    port = 16'($urandom);
    bytes[0] = op;
    bytes[1] = idx;
    bytes[2] = data[15:8];
    bytes[3] = data[7:0];
    bytes[4] = 8'hA5;
    due = model_frame(dport, len, bad_user, op, idx, data, ip, port, rsp);
    rx_hdr.src_ip = ip;
    rx_hdr.src_port = port;
    rx_hdr.dest_port = dport;
    rx_hdr.length = 16'(8 + len);
    rx_hdr_valid = 1'b1;
    do begin
      @(posedge clk);
    end while (!rx_hdr_ready);
    #1;
    rx_hdr_valid = 1'b0;
    // reply expected only once the request header is taken
    if (due) begin
      u_check.add_expected(rsp);
    end
    for (int i = 0; i < len; i++) begin
      rx_payload.tdata = bytes[i];
      rx_payload.tlast = (i == len - 1);
      // error flag on the second byte only
      rx_payload.tuser = bad_user && (i == 1);
      rx_payload_valid = 1'b1;
      do begin
        @(posedge clk);
      end while (!rx_payload_ready);
      #1;
    end
    rx_payload_valid = 1'b0;
  endtask

  task automatic wait_replies();
    while (u_check.pending_replies() != 0) begin
      @(posedge clk);
    end
    #1;
  endtask

  // one digit word per switch setting, registered one cycle after the change
  task automatic sweep_panel();
    logic [31:0] exp_word;
    for (int s = 0; s < 8; s++) begin
      sw = 3'(s);
      if (s < 4) begin
        exp_word = {16'(s), model_regs[s]};
      end else if (s == 4) begin
        exp_word = model_ip;
      end else begin
        exp_word = '0;
      end
      @(posedge clk);
      #1;
      u_check.check_panel(exp_word, model_led);
    end
    sw = 3'd0;
  endtask

  initial begin
    void'($urandom(1));
    rst = 1'b1;
    rx_hdr = '0;
    rx_hdr_valid = 1'b0;
    rx_payload = '0;
    rx_payload_valid = 1'b0;
    tx_hdr_ready = 1'b0;
    tx_payload_ready = 1'b0;
    sw = 3'd0;
    model_ip = '0;
    model_led = '0;
    for (int i = 0; i < 4; i++) begin
      model_regs[i] = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    sweep_panel();
    // reads after reset, writes, read back
    for (int i = 0; i < 4; i++) send_frame(PORT, 4, 1'b0, OP_READ, 8'(i), 16'($urandom));
    for (int i = 0; i < 4; i++) send_frame(PORT, 4, 1'b0, OP_WRITE, 8'(i), 16'($urandom));
    for (int i = 0; i < 4; i++) send_frame(PORT, 4, 1'b0, OP_READ, 8'(i), 16'($urandom));
    // frames that must be dropped
    send_frame(16'd1235, 4, 1'b0, OP_WRITE, 8'd0, 16'($urandom));
    send_frame(PORT, 3, 1'b0, OP_WRITE, 8'd1, 16'($urandom));
    send_frame(PORT, 5, 1'b0, OP_WRITE, 8'd2, 16'($urandom));
    send_frame(PORT, 4, 1'b1, OP_WRITE, 8'd3, 16'($urandom));
    send_frame(PORT, 4, 1'b0, 8'h03, 8'd0, 16'($urandom));
    send_frame(PORT, 4, 1'b0, OP_WRITE, 8'd4, 16'($urandom));
    for (int i = 0; i < 4; i++) send_frame(PORT, 4, 1'b0, OP_READ, 8'(i), 16'($urandom));
    wait_replies();
    sweep_panel();
    // mixed traffic
    for (int i = 0; i < 8; i++) begin
      send_frame(PORT, 4, 1'b0, (($urandom % 2) != 0) ? OP_WRITE : OP_READ,
                 8'($urandom % 4), 16'($urandom));
    end
    wait_replies();
    sweep_panel();
    repeat (5) @(posedge clk);
    end_run(1'b0);
  end

endmodule

/* tb_udp_regs_check.sv */
// reply and panel checker: compares reply headers, reply bytes and front panel with expected values
`timescale 1ns/1ps

module tb_udp_regs_check (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_rx_hdr_valid,
  input  logic                      i_rx_hdr_ready,
  input  udp_regs_pkg::udp_tx_hdr_t i_tx_hdr,
  input  logic                      i_tx_hdr_valid,
  input  logic                      i_tx_hdr_ready,
  input  udp_regs_pkg::axis_byte_t  i_tx_payload,
  input  logic                      i_tx_payload_valid,
  input  logic                      i_tx_payload_ready,
  input  udp_regs_pkg::seg_t [7:0]  i_hex,
  input  logic [7:0]                i_led
);

  // lit segments per hex digit, entry 15 first, bit 0 is segment a
  localparam logic [15:0][6:0] SEG_ON = {
    7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77, 7'h6F, 7'h7F,
    7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F
  };

  udp_regs_pkg::reg_rsp_t    exp_q[$];
  udp_regs_pkg::reg_rsp_t    cur;
  udp_regs_pkg::udp_tx_hdr_t hdr_q;
  udp_regs_pkg::axis_byte_t  byte_q;
  logic [7:0]                exp_byte;
  logic                      in_reply = 1'b0;
  logic                      hdr_stall = 1'b0;
  logic                      byte_stall = 1'b0;
  int                        byte_idx = 0;
  int                        n_value_err = 0;
  int                        n_proto_err = 0;

  task automatic compare_field(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      n_value_err++;
    end
  endtask

  task automatic add_expected(input udp_regs_pkg::reg_rsp_t rsp);
    exp_q.push_back(rsp);
  endtask

  // queued plus the one being sent
  function automatic int pending_replies();
    return exp_q.size() + (in_reply ? 1 : 0);
  endfunction

  // digits are active low on this board
  task automatic check_panel(input logic [31:0] exp_word, input logic [7:0] exp_led);
    udp_regs_pkg::seg_t exp_seg;
    for (int i = 0; i < 8; i++) begin
      exp_seg = ~SEG_ON[exp_word[i*4 +: 4]];
      compare_field($sformatf("digit %0d", i), 32'(i_hex[i]), 32'(exp_seg));
    end
    compare_field("led", 32'(i_led), 32'(exp_led));
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      // request must wait for the reply to finish
      if (i_rx_hdr_valid && i_rx_hdr_ready &&
          ((pending_replies() != 0) || i_tx_hdr_valid || i_tx_payload_valid)) begin
        $display("request header accepted at %0t while a reply was in progress", $time);
        n_proto_err++;
      end
      if (hdr_stall && (!i_tx_hdr_valid || (i_tx_hdr != hdr_q))) begin
        $display("reply header dropped or changed under back-pressure at %0t", $time);
        n_proto_err++;
      end
      if (byte_stall && (!i_tx_payload_valid || (i_tx_payload != byte_q))) begin
        $display("reply byte dropped or changed under back-pressure at %0t", $time);
        n_proto_err++;
      end
      if (i_tx_hdr_valid && i_tx_hdr_ready) begin
        if (exp_q.size() == 0) begin
          $display("reply header at %0t when no reply was expected", $time);
          n_proto_err++;
        end else begin
          cur = exp_q.pop_front();
          // board address, local port, 8 byte udp header plus 4 data bytes
          compare_field("src_ip", i_tx_hdr.src_ip, 32'hC0A8_0180);
          compare_field("dest_ip", i_tx_hdr.dest_ip, cur.ip);
          compare_field("src_port", 32'(i_tx_hdr.src_port), 32'd1234);
          compare_field("dest_port", 32'(i_tx_hdr.dest_port), 32'(cur.port));
          compare_field("length", 32'(i_tx_hdr.length), 32'd12);
          compare_field("ttl", 32'(i_tx_hdr.ttl), 32'd64);
          compare_field("checksum", 32'(i_tx_hdr.checksum), 32'd0);
          in_reply = 1'b1;
          byte_idx = 0;
        end
      end
      if (i_tx_payload_valid && i_tx_payload_ready) begin
        if (!in_reply) begin
          $display("reply byte at %0t without a reply header before it", $time);
          n_proto_err++;
        end else begin
          case (byte_idx)
            0: exp_byte = cur.opcode;
            1: exp_byte = cur.index;
            2: exp_byte = cur.value[15:8];
            default: exp_byte = cur.value[7:0];
          endcase
          compare_field("reply byte", 32'(i_tx_payload.tdata), 32'(exp_byte));
          compare_field("reply tlast", 32'(i_tx_payload.tlast), 32'(byte_idx == 3));
          compare_field("reply tuser", 32'(i_tx_payload.tuser), 32'd0);
          if (i_tx_payload.tlast || (byte_idx == 3)) begin
            in_reply = 1'b0;
          end
          byte_idx++;
        end
      end
      hdr_stall = i_tx_hdr_valid && !i_tx_hdr_ready;
      hdr_q = i_tx_hdr;
      byte_stall = i_tx_payload_valid && !i_tx_payload_ready;
      byte_q = i_tx_payload;
    end
  end

endmodule

/* udp_cmd_parser.sv */
// udp command parser: takes request frames, filters them and strobes register commands
`timescale 1ns/1ps
`include "udp_regs_settings.svh"

module udp_cmd_parser (
  input  logic                      clk,
  input  logic                      rst,
  input  udp_regs_pkg::udp_rx_hdr_t i_rx_hdr,
  input  logic                      i_rx_hdr_valid,
  output logic                      o_rx_hdr_ready,
  input  udp_regs_pkg::axis_byte_t  i_rx_payload,
  input  logic                      i_rx_payload_valid,
  output logic                      o_rx_payload_ready,
  input  logic                      i_reply_busy,
  output udp_regs_pkg::reg_cmd_t    o_cmd,
  output logic                      o_cmd_valid
);

  logic                   in_frame;
  logic [2:0]             byte_cnt;
  logic                   err;
  logic [2:0][7:0]        byte_buf;
  logic [31:0]            req_ip;
  logic [15:0]            req_port;
  logic                   hdr_fire;
  logic                   byte_fire;
  logic                   cmd_ok;
  udp_regs_pkg::reg_cmd_t cmd_next;

  // one request at a time, wait for any command or reply in progress
  assign o_rx_hdr_ready = !in_frame && !i_reply_busy && !o_cmd_valid;
  // whole frame consumed, dropped or not
  assign o_rx_payload_ready = in_frame;

  assign hdr_fire = i_rx_hdr_valid && o_rx_hdr_ready;
  assign byte_fire = i_rx_payload_valid && o_rx_payload_ready;

  // last data byte taken straight from the bus
  always_comb begin
    cmd_next.opcode = byte_buf[0];
    cmd_next.index = byte_buf[1];
    cmd_next.data = {byte_buf[2], i_rx_payload.tdata};
    cmd_next.ip = req_ip;
    cmd_next.port = req_port;
  end

  // drop rules checked on the tlast byte
  assign cmd_ok = (byte_cnt == 3'(`UDP_REGS_CMD_LEN - 1)) &&
                  !err && !i_rx_payload.tuser &&
                  ((cmd_next.opcode == `UDP_REGS_OP_WRITE) ||
                   (cmd_next.opcode == `UDP_REGS_OP_READ)) &&
                  (cmd_next.index < 8'(`UDP_REGS_NUM));

  always_ff @(posedge clk) begin
    if (rst) begin
      in_frame <= 1'b0;
      byte_cnt <= '0;
      err <= 1'b0;
      o_cmd_valid <= 1'b0;
    end else begin
      o_cmd_valid <= 1'b0;
      if (hdr_fire) begin
        in_frame <= 1'b1;
        byte_cnt <= '0;
        // wrong port marks the whole frame bad
        err <= (i_rx_hdr.dest_port != `UDP_REGS_PORT);
      end
      if (byte_fire) begin
        // saturate so long frames never look like 4 bytes
        if (byte_cnt != 3'd7) begin
          byte_cnt <= byte_cnt + 3'd1;
        end
        err <= err | i_rx_payload.tuser;
        if (i_rx_payload.tlast) begin
          in_frame <= 1'b0;
          o_cmd_valid <= cmd_ok;
        end
      end
    end
  end

  // requester address and command bytes
  always_ff @(posedge clk) begin
    if (hdr_fire) begin
      req_ip <= i_rx_hdr.src_ip;
      req_port <= i_rx_hdr.src_port;
    end
    if (byte_fire && (byte_cnt < 3'd3)) begin
      byte_buf[byte_cnt[1:0]] <= i_rx_payload.tdata;
    end
    if (byte_fire && i_rx_payload.tlast) begin
      o_cmd <= cmd_next;
    end
  end

endmodule

/* udp_reg_bank.sv */
// register bank: applies write commands and answers every command with the register value
`timescale 1ns/1ps
`include "udp_regs_settings.svh"

module udp_reg_bank (
  input  logic                                          clk,
  input  logic                                          rst,
  input  udp_regs_pkg::reg_cmd_t                        i_cmd,
  input  logic                                          i_cmd_valid,
  output udp_regs_pkg::reg_rsp_t                        o_rsp,
  output logic                                          o_rsp_valid,
  output logic [`UDP_REGS_NUM-1:0][`UDP_REGS_WIDTH-1:0] o_regs
);

  localparam int IDX_W = $clog2(`UDP_REGS_NUM);

  logic [IDX_W-1:0] idx;
  logic             is_write;

  // index already range checked by the parser
  assign idx = i_cmd.index[IDX_W-1:0];
  assign is_write = (i_cmd.opcode == `UDP_REGS_OP_WRITE);

  // registers and response strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      o_regs <= '0;
      o_rsp_valid <= 1'b0;
    end else begin
      o_rsp_valid <= i_cmd_valid;
      if (i_cmd_valid && is_write) begin
        o_regs[idx] <= i_cmd.data;
      end
    end
  end

  // response carries the value after the command
  always_ff @(posedge clk) begin
    if (i_cmd_valid) begin
      o_rsp.opcode <= i_cmd.opcode;
      o_rsp.index <= i_cmd.index;
      o_rsp.value <= is_write ? i_cmd.data : o_regs[idx];
      o_rsp.ip <= i_cmd.ip;
      o_rsp.port <= i_cmd.port;
    end
  end

endmodule

/* udp_regs_pkg.sv */
// udp register bank types: udp headers, byte stream, command, response and digit
`include "udp_regs_settings.svh"

package udp_regs_pkg;

  // request header as delivered by the udp stack
  typedef struct packed {
    logic [31:0] src_ip;
    logic [15:0] src_port;
    logic [15:0] dest_port;
    logic [15:0] length;
  } udp_rx_hdr_t;

  // reply header towards the udp stack
  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dest_ip;
    logic [15:0] src_port;
    logic [15:0] dest_port;
    logic [15:0] length;
    logic [7:0]  ttl;
    logic [15:0] checksum;
  } udp_tx_hdr_t;

  // one payload byte with frame end and error flag
  typedef struct packed {
    logic [7:0] tdata;
    logic       tlast;
    logic       tuser;
  } axis_byte_t;

  // decoded command, carries the requester for the reply
  typedef struct packed {
    logic [7:0]                 opcode;
    logic [7:0]                 index;
    logic [`UDP_REGS_WIDTH-1:0] data;
    logic [31:0]                ip;
    logic [15:0]                port;
  } reg_cmd_t;

  // register value after the command
  typedef struct packed {
    logic [7:0]                 opcode;
    logic [7:0]                 index;
    logic [`UDP_REGS_WIDTH-1:0] value;
    logic [31:0]                ip;
    logic [15:0]                port;
  } reg_rsp_t;

  // segments g..a, bit 0 is a
  typedef logic [6:0] seg_t;

endpackage

/* udp_regs_settings.svh */
// udp register bank constants: port, addresses, register geometry and display polarity
`ifndef UDP_REGS_SETTINGS_SVH
`define UDP_REGS_SETTINGS_SVH

// local udp port, commands on other ports are dropped
`define UDP_REGS_PORT 16'd1234

// board address, 192.168.1.128
`define UDP_REGS_LOCAL_IP 32'hC0_A8_01_80

// register array geometry
`define UDP_REGS_NUM 4
`define UDP_REGS_WIDTH 16

// command and reply payload length in bytes
`define UDP_REGS_CMD_LEN 4

// ip ttl of the reply
`define UDP_REGS_TTL 8'd64

// 1 means segments are active low
`define UDP_REGS_HEX_INVERT 1

// command opcodes, first payload byte
`define UDP_REGS_OP_WRITE 8'h01
`define UDP_REGS_OP_READ 8'h02

`endif

/* udp_regs_top.sv */
// udp register bank top: parser, register bank, reply sender and front panel
`timescale 1ns/1ps
`include "udp_regs_settings.svh"

module udp_regs_top (
  input  logic                      clk,
  input  logic                      rst,
  // request side from the udp stack
  input  udp_regs_pkg::udp_rx_hdr_t i_rx_hdr,
  input  logic                      i_rx_hdr_valid,
  output logic                      o_rx_hdr_ready,
  input  udp_regs_pkg::axis_byte_t  i_rx_payload,
  input  logic                      i_rx_payload_valid,
  output logic                      o_rx_payload_ready,
  // reply side to the udp stack
  output udp_regs_pkg::udp_tx_hdr_t o_tx_hdr,
  output logic                      o_tx_hdr_valid,
  input  logic                      i_tx_hdr_ready,
  output udp_regs_pkg::axis_byte_t  o_tx_payload,
  output logic                      o_tx_payload_valid,
  input  logic                      i_tx_payload_ready,
  // front panel
  input  logic [2:0]                i_sw,
  output udp_regs_pkg::seg_t [7:0]  o_hex,
  output logic [7:0]                o_led
);

  udp_regs_pkg::reg_cmd_t                        cmd;
  logic                                          cmd_valid;
  udp_regs_pkg::reg_rsp_t                        rsp;
  logic                                          rsp_valid;
  logic                                          reply_busy;
  logic [`UDP_REGS_NUM-1:0][`UDP_REGS_WIDTH-1:0] regs;
  logic [31:0]                                   hex_word;

  udp_cmd_parser u_parser (
    .clk                (clk),
    .rst                (rst),
    .i_rx_hdr           (i_rx_hdr),
    .i_rx_hdr_valid     (i_rx_hdr_valid),
    .o_rx_hdr_ready     (o_rx_hdr_ready),
    .i_rx_payload       (i_rx_payload),
    .i_rx_payload_valid (i_rx_payload_valid),
    .o_rx_payload_ready (o_rx_payload_ready),
    .i_reply_busy       (reply_busy),
    .o_cmd              (cmd),
    .o_cmd_valid        (cmd_valid)
  );

  udp_reg_bank u_bank (
    .clk         (clk),
    .rst         (rst),
    .i_cmd       (cmd),
    .i_cmd_valid (cmd_valid),
    .o_rsp       (rsp),
    .o_rsp_valid (rsp_valid),
    .o_regs      (regs)
  );

  udp_reply_tx u_reply (
    .clk                (clk),
    .rst                (rst),
    .i_rsp              (rsp),
    .i_rsp_valid        (rsp_valid),
    .o_busy             (reply_busy),
    .o_tx_hdr           (o_tx_hdr),
    .o_tx_hdr_valid     (o_tx_hdr_valid),
    .i_tx_hdr_ready     (i_tx_hdr_ready),
    .o_tx_payload       (o_tx_payload),
    .o_tx_payload_valid (o_tx_payload_valid),
    .i_tx_payload_ready (i_tx_payload_ready)
  );

  front_panel u_panel (
    .clk         (clk),
    .rst         (rst),
    .i_sw        (i_sw),
    .i_regs      (regs),
    .i_rsp       (rsp),
    .i_rsp_valid (rsp_valid),
    .o_hex_word  (hex_word),
    .o_led       (o_led)
  );

  seg_decoder u_seg (
    .i_hex_word (hex_word),
    .o_hex      (o_hex)
  );

endmodule

/* udp_reply_tx.sv */
// reply sender: sends the udp reply header and then the four reply bytes
`timescale 1ns/1ps
`include "udp_regs_settings.svh"

module udp_reply_tx (
  input  logic                      clk,
  input  logic                      rst,
  input  udp_regs_pkg::reg_rsp_t    i_rsp,
  input  logic                      i_rsp_valid,
  output logic                      o_busy,
  output udp_regs_pkg::udp_tx_hdr_t o_tx_hdr,
  output logic                      o_tx_hdr_valid,
  input  logic                      i_tx_hdr_ready,
  output udp_regs_pkg::axis_byte_t  o_tx_payload,
  output logic                      o_tx_payload_valid,
  input  logic                      i_tx_payload_ready
);

  localparam logic [1:0] LAST_BYTE = 2'(`UDP_REGS_CMD_LEN - 1);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_HDR,
    TX_DATA
  } tx_state_t;

  tx_state_t              state;
  logic [1:0]             byte_cnt;
  udp_regs_pkg::reg_rsp_t rsp_q;

  // busy already in the response cycle so the parser holds off
  assign o_busy = (state != TX_IDLE) || i_rsp_valid;

  assign o_tx_hdr_valid = (state == TX_HDR);
  assign o_tx_payload_valid = (state == TX_DATA);

  // header built from the held response
  always_comb begin
    o_tx_hdr.src_ip = `UDP_REGS_LOCAL_IP;
    o_tx_hdr.dest_ip = rsp_q.ip;
    o_tx_hdr.src_port = `UDP_REGS_PORT;
    o_tx_hdr.dest_port = rsp_q.port;
    // udp header plus payload
    o_tx_hdr.length = 16'd8 + 16'(`UDP_REGS_CMD_LEN);
    o_tx_hdr.ttl = `UDP_REGS_TTL;
    o_tx_hdr.checksum = 16'd0;
  end

  // byte order: opcode, index, value high, value low
  always_comb begin
    case (byte_cnt)
      2'd0: o_tx_payload.tdata = rsp_q.opcode;
      2'd1: o_tx_payload.tdata = rsp_q.index;
      2'd2: o_tx_payload.tdata = rsp_q.value[15:8];
      default: o_tx_payload.tdata = rsp_q.value[7:0];
    endcase
    o_tx_payload.tlast = (byte_cnt == LAST_BYTE);
    o_tx_payload.tuser = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= TX_IDLE;
      byte_cnt <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (i_rsp_valid) begin
            state <= TX_HDR;
          end
        end
        TX_HDR: begin
          if (i_tx_hdr_ready) begin
            state <= TX_DATA;
            byte_cnt <= '0;
          end
        end
        TX_DATA: begin
          // hold byte while stalled
          if (i_tx_payload_ready) begin
            byte_cnt <= byte_cnt + 2'd1;
            if (byte_cnt == LAST_BYTE) begin
              state <= TX_IDLE;
            end
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // response held for the whole reply
  always_ff @(posedge clk) begin
    if (i_rsp_valid && (state == TX_IDLE)) begin
      rsp_q <= i_rsp;
    end
  end

endmodule
